/* src.f */
+incdir+verif
design/blake2b_pkg.sv
design/hash_stream_pkg.sv
design/blake2b_g.sv
design/blake2b_round_ctr.sv
design/blake2b_ctrl.sv
design/blake2b_state.sv
design/blake2b_core_top.sv
verif/blake2b_tb.sv

/* verif/blake2b_ref.svh */
// BLAKE2b reference model, single-block unkeyed compression from a raw parameter block
`ifndef BLAKE2B_REF_SVH
`define BLAKE2B_REF_SVH

localparam int MODEL_ROUNDS = 12;

// SHA-512 IV, word 0 in the low bits
localparam logic [7:0][63:0] MODEL_IV = {
  64'h5be0cd19137e2179, 64'h1f83d9abfb41bd6b, 64'h9b05688c2b3e6c1f, 64'h510e527fade682d1,
  64'ha54ff53a5f1d36f1, 64'h3c6ef372fe94f82b, 64'hbb67ae8584caa73b, 64'h6a09e667f3bcc908
};

function automatic logic [63:0] rotr64(input logic [63:0] x, input int n);
  return (x >> n) | (x << (64 - n));
endfunction

// SIGMA row as nibbles, entry i in bits [4i+3:4i]
function automatic logic [63:0] sigma_row(input int r);
  case (r % 10)
    0: return 64'hfedcba9876543210;
    1: return 64'h357b20c16df984ae;
    2: return 64'h491763eadf250c8b;
    3: return 64'h8f04a562ebcd1397;
    4: return 64'hd386cb1efa427509;
    5: return 64'h91ef57d438b0a6c2;
    6: return 64'hb8293670a4def15c;
    7: return 64'ha2684f05931ce7bd;
    8: return 64'h5a417d2c803b9ef6;
    default: return 64'h0dc3e9bf5167482a;
  endcase
endfunction

// RFC 7693 G on words a, b, c, d of the work vector
function automatic logic [15:0][63:0] mix_g(input logic [15:0][63:0] vin,
    input int a, input int b, input int c, input int d, input logic [63:0] x,
    input logic [63:0] y);
  logic [15:0][63:0] v;
  v    = vin;
  v[a] = v[a] + v[b] + x;
  v[d] = rotr64(v[d] ^ v[a], 32);
  v[c] = v[c] + v[d];
  v[b] = rotr64(v[b] ^ v[c], 24);
  v[a] = v[a] + v[b] + y;
  v[d] = rotr64(v[d] ^ v[a], 16);
  v[c] = v[c] + v[d];
  v[b] = rotr64(v[b] ^ v[c], 63);
  return v;
endfunction

// Whole hash of a one-block message, block is always the final one
function automatic logic [511:0] compress_block(input logic [1023:0] blk,
    input logic [7:0] len, input logic [511:0] par);
  logic [7:0][63:0]  h;
  logic [15:0][63:0] v;
  logic [15:0][63:0] m;
  logic [63:0]       s;
  m     = blk;
  h     = par ^ MODEL_IV;
  v     = {MODEL_IV, h};
  v[12] = v[12] ^ {56'd0, len};  // Byte counter t0
  v[14] = ~v[14];                // Final block flag
  for (int r = 0; r < MODEL_ROUNDS; r++) begin
    s = sigma_row(r);
    v = mix_g(v, 0, 4,  8, 12, m[s[3:0]],   m[s[7:4]]);
    v = mix_g(v, 1, 5,  9, 13, m[s[11:8]],  m[s[15:12]]);
    v = mix_g(v, 2, 6, 10, 14, m[s[19:16]], m[s[23:20]]);
    v = mix_g(v, 3, 7, 11, 15, m[s[27:24]], m[s[31:28]]);
    v = mix_g(v, 0, 5, 10, 15, m[s[35:32]], m[s[39:36]]);  // Diagonals
    v = mix_g(v, 1, 6, 11, 12, m[s[43:40]], m[s[47:44]]);
    v = mix_g(v, 2, 7,  8, 13, m[s[51:48]], m[s[55:52]]);
    v = mix_g(v, 3, 4,  9, 14, m[s[59:56]], m[s[63:60]]);
  end
  return h ^ v[7:0] ^ v[15:8];
endfunction

`endif

/* verif/blake2b_tb.sv */
// Testbench for the iterative BLAKE2b core with a vector table, reference model and back-pressure
`timescale 1ns/1ps

module blake2b_tb;
  import hash_stream_pkg::*;

  `include "blake2b_ref.svh"

  localparam int  NUM_ROUNDS = 12;
  localparam int  LATENCY    = 2 * NUM_ROUNDS + 1;  // Accept edge to o_hash_val
  localparam real CLK_PERIOD = 4.0;
  localparam real DRV_DLY    = 0.5;                 // Input drive after rising edge

  // RFC 7693 Appendix A digest of "abc" with byte 0 low
  localparam logic [511:0] KAT_ABC = {
    256'h239900d4ed8623b9_5a92f1dba88ad318_95cc3345ded552c2_2d79ab2a39c5877d,
    256'hd1a2ffdb6fbb124b_b7c45a68142f214c_e9f6129fb697276a_0d4d1c983fa580ba
  };

  typedef struct packed {
    logic [7:0]   byte_len;
    logic [63:0]  param0;   // Parameter word 0 with upper words zero
    logic [7:0]   tag;
    logic [7:0]   stall;    // Cycles with i_hash_rdy held low
    logic         is_kat;   // Message "abc" with fixed digest
    logic [511:0] digest;
  } vec_t;

  logic         i_clk;
  logic         i_rst;
  hash_in_t     i_block;
  logic         i_block_val;
  logic         o_block_rdy;
  logic [511:0] i_parameters;
  hash_out_t    o_hash;
  logic         o_hash_val;
  logic         i_hash_rdy;

  vec_t         vec_q[$];
  logic [31:0]  lcg_state;
  int           max_stall;
  logic         table_done;

  blake2b_core_top dut_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_block      (i_block),
    .i_block_val  (i_block_val),
    .o_block_rdy  (o_block_rdy),
    .i_parameters (i_parameters),
    .o_hash       (o_hash),
    .o_hash_val   (o_hash_val),
    .i_hash_rdy   (i_hash_rdy)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];  // High bits have the longest period
  endfunction

  task automatic check_eq(input logic [511:0] got, input logic [511:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Run aborted");
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #(DRV_DLY);
  endtask

  task automatic add_vec(input int len, input logic [63:0] p0, input logic [7:0] tag,
                         input int stall, input logic kat, input logic [511:0] digest);
    vec_t e;
    e.byte_len = len[7:0];
    e.param0   = p0;
    e.tag      = tag;
    e.stall    = stall[7:0];
    e.is_kat   = kat;
    e.digest   = digest;
    vec_q.push_back(e);
    if (stall > max_stall) max_stall = stall;
  endtask

  // One message through both handshakes with block ready known high on entry
  task automatic run_vec(input vec_t e);
    logic [1023:0] blk;
    logic [511:0]  par;
    logic [511:0]  expected;
    hash_out_t     held;
    int            n;
    blk = '0;  // Bytes past the length stay zero
    if (e.is_kat) begin
      blk[23:0] = 24'h636261;
    end else begin
      for (int i = 0; i < e.byte_len; i++) begin
        blk[8*i +: 8] = lcg_next();
      end
    end
    par      = {448'd0, e.param0};
    expected = compress_block(blk, e.byte_len, par);
    if (e.is_kat) begin
      check_eq(expected, e.digest, "reference model against RFC 7693 digest");
    end
    i_block.dat      = blk;
    i_block.byte_len = e.byte_len;
    i_block.ctl      = e.tag;
    i_parameters     = par;
    i_block_val      = 1'b1;
    next_cycle();                 // Accept edge
    i_block_val  = 1'b0;
    i_block      = '0;            // Core must have sampled everything already
    i_parameters = '0;
    check_eq(o_block_rdy, 1'b0, "o_block_rdy after accept");
    n = 0;
    while (!o_hash_val) begin
      next_cycle();
      n++;
      if (n > LATENCY + 10) abort_run("Timeout: o_hash_val never rose after the block was taken");
      check_eq(o_block_rdy, 1'b0, "o_block_rdy while hashing");
    end
    check_eq(n, LATENCY, "edges from accept to o_hash_val");
    held = o_hash;
    repeat (e.stall) begin
      next_cycle();
      check_eq(o_hash_val, 1'b1, "o_hash_val under back-pressure");
      check_eq(o_hash.dat, held.dat, "o_hash.dat under back-pressure");
      check_eq(o_hash.ctl, held.ctl, "o_hash.ctl under back-pressure");
      check_eq(o_block_rdy, 1'b0, "o_block_rdy under back-pressure");
    end
    check_eq(o_hash.dat, expected, $sformatf("digest for tag %02h", e.tag));
    check_eq(o_hash.ctl, e.tag, "returned tag");
    i_hash_rdy = 1'b1;
    next_cycle();                 // Output taken
    i_hash_rdy = 1'b0;
    check_eq(o_hash_val, 1'b0, "o_hash_val after output accept");
    check_eq(o_block_rdy, 1'b1, "o_block_rdy after output accept");
  endtask

  initial begin
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    i_block      = '0;
    i_block_val  = 1'b0;
    i_parameters = '0;
    i_hash_rdy   = 1'b0;
    lcg_state    = 32'headc_4597;
    max_stall    = 0;
    table_done   = 1'b0;
    // Length, parameter word 0, tag, stall, known answer flag, digest
    add_vec(3,   64'h01010040, 8'ha1, 0, 1'b1, KAT_ABC);
    add_vec(0,   64'h01010040, 8'h10, 2, 1'b0, '0);
    add_vec(1,   64'h01010040, 8'h11, 0, 1'b0, '0);
    add_vec(63,  64'h01010040, 8'h12, 5, 1'b0, '0);
    add_vec(64,  64'h01010040, 8'h13, 1, 1'b0, '0);
    add_vec(127, 64'h01010040, 8'h14, 0, 1'b0, '0);
    add_vec(128, 64'h01010040, 8'h15, 7, 1'b0, '0);
    add_vec(50,  64'h01010020, 8'h20, 3, 1'b0, '0);  // 32-byte digest length
    add_vec(100, 64'h01020040, 8'h21, 0, 1'b0, '0);  // Fanout 2
    add_vec(128, 64'hff000040, 8'h22, 4, 1'b0, '0);  // Fanout 0 and depth 255
    add_vec(3,   64'h01010040, 8'h23, 1, 1'b0, '0);
    table_done = 1'b1;
    repeat (3) @(posedge i_clk);
    #(DRV_DLY);
    i_rst = 1'b0;
    check_eq(o_hash_val, 1'b0, "o_hash_val after reset");
    check_eq(o_block_rdy, 1'b1, "o_block_rdy after reset");
    foreach (vec_q[k]) begin
      run_vec(vec_q[k]);  // Strictly in table order
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog sized from the table and the longest stall
  initial begin : watchdog
    real limit;
    wait (table_done);
    limit = vec_q.size() * (2 * NUM_ROUNDS + 3 + max_stall + 10) * CLK_PERIOD;
    #(limit);
    $display("Timeout: the vector table did not finish within %0.1f ns", limit);
    $display("*** TEST FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* design/blake2b_core_top.sv */
// Iterative single-block BLAKE2b core with valid/ready streams on both sides
`timescale 1ns/1ps

module blake2b_core_top #(
  parameter int NUM_ROUNDS = 12   // 12 for BLAKE2b, lower only for reduced-round use
) (
  input  logic                       i_clk,
  input  logic                       i_rst,
  // Message block in
  input  hash_stream_pkg::hash_in_t  i_block,
  input  logic                       i_block_val,
  output logic                       o_block_rdy,
  input  logic [511:0]               i_parameters,  // Sampled with the block
  // Chaining value out
  output hash_stream_pkg::hash_out_t o_hash,
  output logic                       o_hash_val,
  input  logic                       i_hash_rdy
);

  logic       do_load;    // Accept edge
  logic       do_mix;
  logic       do_final;
  logic       ctr_clear;
  logic       ctr_step;
  logic       ctr_last;
  logic [3:0] ctr_round;  // SIGMA row
  logic       ctr_diag;

  blake2b_ctrl ctrl_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_block_val (i_block_val),
    .o_block_rdy (o_block_rdy),
    .o_hash_val  (o_hash_val),
    .i_hash_rdy  (i_hash_rdy),
    .i_last      (ctr_last),
    .o_clear     (ctr_clear),
    .o_step      (ctr_step),
    .o_load      (do_load),
    .o_mix       (do_mix),
    .o_final     (do_final)
  );

  blake2b_round_ctr #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) round_ctr_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_clear (ctr_clear),
    .i_step  (ctr_step),
    .o_round (ctr_round),
    .o_diag  (ctr_diag),
    .o_last  (ctr_last)
  );

  blake2b_state state_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_load       (do_load),
    .i_mix        (do_mix),
    .i_final      (do_final),
    .i_block      (i_block),
    .i_parameters (i_parameters),
    .i_round      (ctr_round),
    .i_diag       (ctr_diag),
    .o_hash       (o_hash)
  );

endmodule

/* design/blake2b_state.sv */
// BLAKE2b compression datapath with h, work vector and message registers and four G lanes
`timescale 1ns/1ps

module blake2b_state (
  input  logic                       i_clk,
  input  logic                       i_rst,
  // Strobes from the controller
  input  logic                       i_load,
  input  logic                       i_mix,
  input  logic                       i_final,
  // Block and parameter block sampled on load
  input  hash_stream_pkg::hash_in_t  i_block,
  input  logic [511:0]               i_parameters,
  // Half-round position from the counter
  input  logic [3:0]                 i_round,
  input  logic                       i_diag,
  output hash_stream_pkg::hash_out_t o_hash
);
  import blake2b_pkg::*;
  import hash_stream_pkg::*;

  // Four words seen by one G lane
  typedef struct packed {
    word_t a;
    word_t b;
    word_t c;
    word_t d;
  } lane_t;

  word_t [7:0]         h;         // Chaining value
  word_t [15:0]        v;         // Local work vector
  word_t [15:0]        msg;       // Message words m[0..15]
  logic [CTL_BITS-1:0] tag;       // Tag travels alongside the hash

  word_t [7:0]         h_init;    // Parameters XOR IV
  word_t [15:0]        v_init;
  word_t [7:0]         h_fin;
  word_t [15:0]        v_mix;     // Work vector after this half-round

  logic [3:0]          lane_idx [4][4];  // Work vector index per lane and position
  lane_t               lane_in  [4];
  lane_t               lane_out [4];
  word_t               lane_m0  [4];
  word_t               lane_m1  [4];

  // Initial state of the only block, which is always the last one
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      h_init[i]   = i_parameters[64*i +: 64] ^ IV[i];
      v_init[i]   = h_init[i];
      v_init[i+8] = IV[i];
    end
    v_init[12] = IV[4] ^ 64'(i_block.byte_len); // Byte counter in the low word only
    v_init[14] = ~IV[6];                        // Last block flag
  end

  // Column or diagonal lane selection and SIGMA message pick
  always_comb begin
    for (int g = 0; g < 4; g++) begin
      for (int k = 0; k < 4; k++) begin
        lane_idx[g][k] = G_MAPPING[(i_diag ? 16 : 0) + 4*g + k];
      end
      lane_in[g].a = v[lane_idx[g][0]];
      lane_in[g].b = v[lane_idx[g][1]];
      lane_in[g].c = v[lane_idx[g][2]];
      lane_in[g].d = v[lane_idx[g][3]];
      lane_m0[g]   = msg[SIGMA[i_round][(i_diag ? 8 : 0) + 2*g]];
      lane_m1[g]   = msg[SIGMA[i_round][(i_diag ? 8 : 0) + 2*g + 1]];
    end
  end

  // Four G functions per half-round on disjoint words
  for (genvar g = 0; g < 4; g++) begin : g_lane
    blake2b_g g_i (
      .i_a  (lane_in[g].a),
      .i_b  (lane_in[g].b),
      .i_c  (lane_in[g].c),
      .i_d  (lane_in[g].d),
      .i_m0 (lane_m0[g]),
      .i_m1 (lane_m1[g]),
      .o_a  (lane_out[g].a),
      .o_b  (lane_out[g].b),
      .o_c  (lane_out[g].c),
      .o_d  (lane_out[g].d)
    );
  end

  // Scatter lane results back to their work vector slots
  always_comb begin
    v_mix = v;
    for (int g = 0; g < 4; g++) begin
      v_mix[lane_idx[g][0]] = lane_out[g].a;
      v_mix[lane_idx[g][1]] = lane_out[g].b;
      v_mix[lane_idx[g][2]] = lane_out[g].c;
      v_mix[lane_idx[g][3]] = lane_out[g].d;
    end
  end

  // Feed-forward of both work vector halves
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      h_fin[i] = h[i] ^ v[i] ^ v[i+8];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      v   <= v_init;
      msg <= i_block.dat;
    end else if (i_mix) begin
      v <= v_mix;
    end
  end

  // Chaining value and tag seen on o_hash
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      h   <= '0;
      tag <= '0;
    end else if (i_load) begin
      h   <= h_init;
      tag <= i_block.ctl;
    end else if (i_final) begin
      h <= h_fin;
    end
  end

  assign o_hash.dat = h;
  assign o_hash.ctl = tag;

endmodule

/* design/blake2b_ctrl.sv */
// Hash core controller: stream handshakes and load, mix and finalize strobes
`timescale 1ns/1ps

module blake2b_ctrl (
  input  logic i_clk,
  input  logic i_rst,
  // Input stream handshake
  input  logic i_block_val,
  output logic o_block_rdy,
  // Output stream handshake
  output logic o_hash_val,
  input  logic i_hash_rdy,
  // Round counter
  input  logic i_last,      // Current half-round is the final one
  output logic o_clear,
  output logic o_step,
  // Datapath strobes
  output logic o_load,
  output logic o_mix,
  output logic o_final
);
  import hash_stream_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        accept;    // Input beat taken this edge
  logic        out_take;  // Output beat taken this edge

  // Handshakes are only evaluated here
  assign accept   = (state == ST_IDLE) && i_block_val;
  assign out_take = (state == ST_OUT) && i_hash_rdy;

  always_comb begin
    state_nxt = state;
    unique case (state)
      ST_IDLE: begin
        if (accept) state_nxt = ST_MIX;
      end
      ST_MIX: begin
        if (i_last) state_nxt = ST_FINAL;  // Last half-round runs this edge
      end
      ST_FINAL: begin
        state_nxt = ST_OUT;                // h folded in one cycle
      end
      ST_OUT: begin
        if (out_take) state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Load state and restart the counter on the accept edge
  assign o_load  = accept;
  assign o_clear = accept;

  // One half-round per cycle while mixing
  assign o_mix  = (state == ST_MIX);
  assign o_step = (state == ST_MIX);

  assign o_final = (state == ST_FINAL);

  // Stream flags follow the state directly
  assign o_block_rdy = (state == ST_IDLE);  // One message in flight at most
  assign o_hash_val  = (state == ST_OUT);

endmodule

/* design/blake2b_round_ctr.sv */
// Half-round sequencer for the iterative compression, with SIGMA row and last-step flag
`timescale 1ns/1ps

module blake2b_round_ctr #(
  parameter int NUM_ROUNDS = 12
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_clear,   // Restart at half-round 0
  input  logic       i_step,    // Advance one half-round
  output logic [3:0] o_round,   // Round index mod 10, selects SIGMA row
  output logic       o_diag,    // 0 column step, 1 diagonal step
  output logic       o_last     // Final half-round of the block
);

  localparam int HALF_ROUNDS = 2 * NUM_ROUNDS;
  localparam int CNT_W       = (HALF_ROUNDS > 1) ? $clog2(HALF_ROUNDS) : 1;

  logic [CNT_W-1:0] half_cnt;   // 0 .. HALF_ROUNDS-1
  logic [3:0]       sigma_idx;  // Kept separately so no divider is needed
  logic             last_step;

  assign last_step = (half_cnt == CNT_W'(HALF_ROUNDS - 1));
  assign o_last    = last_step;
  assign o_diag    = half_cnt[0];  // Low bit alternates column and diagonal
  assign o_round   = sigma_idx;

  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      half_cnt  <= '0;
      sigma_idx <= '0;
    end else if (i_step) begin
      half_cnt <= last_step ? '0 : half_cnt + 1'b1;
      // Round ends after its diagonal step
      if (half_cnt[0]) begin
        sigma_idx <= (last_step || sigma_idx == 4'd9) ? 4'd0 : sigma_idx + 4'd1;
      end
    end
  end

endmodule

/* design/blake2b_g.sv */
// BLAKE2b G mixing function, combinational, on four state words and two message words
`timescale 1ns/1ps

module blake2b_g (
  input  blake2b_pkg::word_t i_a,
  input  blake2b_pkg::word_t i_b,
  input  blake2b_pkg::word_t i_c,
  input  blake2b_pkg::word_t i_d,
  input  blake2b_pkg::word_t i_m0,
  input  blake2b_pkg::word_t i_m1,
  output blake2b_pkg::word_t o_a,
  output blake2b_pkg::word_t o_b,
  output blake2b_pkg::word_t o_c,
  output blake2b_pkg::word_t o_d
);
  import blake2b_pkg::*;

  word_t a1, b1, c1, d1;  // After first half of G
  word_t dx, bx;          // XOR terms ahead of rotation

  always_comb begin
    // First half, rotations 32 and 24
    a1 = i_a + i_b + i_m0;
    dx = i_d ^ a1;
    d1 = {dx[31:0], dx[63:32]};     // ror 32
    c1 = i_c + d1;
    bx = i_b ^ c1;
    b1 = {bx[23:0], bx[63:24]};     // ror 24
    // Second half, rotations 16 and 63
    o_a = a1 + b1 + i_m1;
    dx  = d1 ^ o_a;
    o_d = {dx[15:0], dx[63:16]};    // ror 16
    o_c = c1 + o_d;
    bx  = b1 ^ o_c;
    o_b = {bx[62:0], bx[63]};       // ror 63, same as rol 1
  end

endmodule

/* design/hash_stream_pkg.sv */
// Stream beat types for the hash core and its control state encoding
package hash_stream_pkg;

  localparam int CTL_BITS = 8;  // User tag width, returned unchanged with the hash

  // Input beat, one whole message block
  typedef struct packed {
    logic [blake2b_pkg::BLOCK_BYTES*8-1:0] dat;  // Byte 0 in bits [7:0], zero padded
    logic [7:0]                            byte_len; // 0 to 128
    logic [CTL_BITS-1:0]                   ctl;      // Tag
  } hash_in_t;

  // Output beat, full 512-bit chaining value
  typedef struct packed {
    logic [511:0]        dat;   // Word 0 of h in the low bits
    logic [CTL_BITS-1:0] ctl;   // Tag of the message
  } hash_out_t;

  // Controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // Waiting for a block
    ST_MIX   = 2'd1,  // Running half-rounds
    ST_FINAL = 2'd2,  // Fold work vector into h
    ST_OUT   = 2'd3   // Holding result until taken
  } ctrl_state_e;

endpackage

/* design/blake2b_pkg.sv */
// BLAKE2b algorithm constants: word type, IV, message schedule and G lane mapping
package blake2b_pkg;

  typedef logic [63:0] word_t;    // One BLAKE2b state word

  localparam int BLOCK_BYTES = 128; // Message block size in bytes

  // Initialization vector, same as SHA-512, word 0 first
  localparam word_t IV [8] = '{
    64'h6a09e667f3bcc908,
    64'hbb67ae8584caa73b,
    64'h3c6ef372fe94f82b,
    64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1,
    64'h9b05688c2b3e6c1f,
    64'h1f83d9abfb41bd6b,
    64'h5be0cd19137e2179
  };

  // Message word permutation per round, rounds 10 and 11 reuse rows 0 and 1
  localparam logic [3:0] SIGMA [10][16] = '{
    '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
    '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
    '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
    '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
    '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
    '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
    '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
    '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10},
    '{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
    '{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
  };

  // Work vector indices (a, b, c, d) for each of the four G lanes
  // First 16 entries are the column step, last 16 the diagonal step
  localparam logic [3:0] G_MAPPING [32] = '{
    0,  4,  8, 12,   // Column lane 0
    1,  5,  9, 13,   // Column lane 1
    2,  6, 10, 14,   // Column lane 2
    3,  7, 11, 15,   // Column lane 3
    0,  5, 10, 15,   // Diagonal lane 0
    1,  6, 11, 12,   // Diagonal lane 1
    2,  7,  8, 13,   // Diagonal lane 2
    3,  4,  9, 14    // Diagonal lane 3
  };

endpackage
